//--- Makefile
SIM := obj_dir/Vtage_update_tb

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): verilog.f $(wildcard design/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert --top-module tage_update_tb \
		-f verilog.f -Mdir obj_dir

run: $(SIM) verif/tage_update_testdata.txt
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/counter_update.sv
`default_nettype none

// prediction counter direction for the provider bank
// a correct prediction strengthens the counter, a mispredict weakens it
module counter_update (
	input  tage_update_pkg::bank_vec_t provider,
	input  tage_update_pkg::bank_vec_t bank_pred,
	input  logic                       mispredict,
	output tage_update_pkg::bank_vec_t ctr_inc_nx,
	output tage_update_pkg::bank_vec_t ctr_dec_nx
);

	// per bank: 1 means move the counter toward taken
	tage_update_pkg::bank_vec_t toward_taken;

	// correct and taken -> count up
	// correct and not taken -> count down
	// wrong and taken -> count down (weaken)
	// wrong and not taken -> count up (weaken)
	assign toward_taken = bank_pred ^ {tage_update_pkg::NUM_BANKS{mispredict}};

	// only the provider counter ever moves
	assign ctr_inc_nx = provider & toward_taken;
	assign ctr_dec_nx = provider & ~toward_taken;

endmodule

`default_nettype wire

//--- design/provider_select.sv
`default_nettype none

// picks the provider bank and the alternate hits
// longest history wins, bimodal bank 0 is the fallback
module provider_select (
	input  tage_update_pkg::tag_vec_t  hit,
	output tage_update_pkg::bank_vec_t provider,
	output tage_update_pkg::tag_vec_t  alt_hit
);

	always_comb begin
		logic found;	// a higher bank already claimed the provider role

		found    = 1'b0;
		provider = '0;
		alt_hit  = '0;

		// search from the longest history table downward
		for (int i = tage_update_pkg::NUM_TAGGED; i >= 1; i--) begin
			if (hit[i] && !found) begin
				provider[i] = 1'b1;
				found       = 1'b1;
			end else if (hit[i]) begin
				alt_hit[i] = 1'b1;	// hit below the provider
			end
		end

		if (!found) begin
			provider[0] = 1'b1;	// no tag match, bimodal predicts
		end
	end

endmodule

`default_nettype wire

//--- design/tage_update.sv
`default_nettype none

// TAGE update controller, one bimodal and four tagged banks
// decisions are combinational, outputs come one clock after the strobe
module tage_update (
	input  logic                       CLK,
	input  logic                       rst_n,
	input  logic                       update_en,
	input  logic                       pred_final,
	input  logic                       outcome,
	input  tage_update_pkg::tag_vec_t  hit,
	input  tage_update_pkg::bank_vec_t bank_pred,
	input  tage_update_pkg::u_bits_t   u_bits,
	output tage_update_pkg::bank_vec_t ctr_inc,
	output tage_update_pkg::bank_vec_t ctr_dec,
	output tage_update_pkg::tag_vec_t  u_inc,
	output tage_update_pkg::tag_vec_t  u_dec,
	output logic                       alloc
);

	tage_update_pkg::bank_vec_t provider;
	tage_update_pkg::tag_vec_t  alt_hit;
	logic                       mispredict;

	// next-cycle decisions
	tage_update_pkg::bank_vec_t ctr_inc_nx;
	tage_update_pkg::bank_vec_t ctr_dec_nx;
	tage_update_pkg::tag_vec_t  u_inc_nx;
	tage_update_pkg::tag_vec_t  u_dec_nx;
	logic                       alloc_nx;

	provider_select sel_i (
		.hit      (hit),
		.provider (provider),
		.alt_hit  (alt_hit)
	);

	counter_update ctr_i (
		.provider   (provider),
		.bank_pred  (bank_pred),
		.mispredict (mispredict),
		.ctr_inc_nx (ctr_inc_nx),
		.ctr_dec_nx (ctr_dec_nx)
	);

	useful_alloc use_i (
		.provider   (provider),
		.alt_hit    (alt_hit),
		.bank_pred  (bank_pred),
		.pred_final (pred_final),
		.mispredict (mispredict),
		.u_bits     (u_bits),
		.u_inc_nx   (u_inc_nx),
		.u_dec_nx   (u_dec_nx),
		.alloc_nx   (alloc_nx)
	);

	update_commit commit_i (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.update_en  (update_en),
		.pred_final (pred_final),
		.outcome    (outcome),
		.mispredict (mispredict),
		.ctr_inc_nx (ctr_inc_nx),
		.ctr_dec_nx (ctr_dec_nx),
		.u_inc_nx   (u_inc_nx),
		.u_dec_nx   (u_dec_nx),
		.alloc_nx   (alloc_nx),
		.ctr_inc    (ctr_inc),
		.ctr_dec    (ctr_dec),
		.u_inc      (u_inc),
		.u_dec      (u_dec),
		.alloc      (alloc)
	);

endmodule

`default_nettype wire

//--- design/tage_update_pkg.sv
`default_nettype none

// shared sizes and vector types for the TAGE update controller
package tage_update_pkg;

	// bank 0 is the bimodal table, banks 1..4 are tagged
	localparam int NUM_BANKS  = 5;
	localparam int NUM_TAGGED = 4;

	localparam int U_WIDTH = 2;	// usefulness field per tagged entry

	// one bit per bank, bit 0 is bimodal
	typedef logic [NUM_BANKS-1:0] bank_vec_t;

	// one bit per tagged bank, indexed by bank number
	typedef logic [NUM_TAGGED:1] tag_vec_t;

	// usefulness of every tagged bank, u_bits[i] belongs to bank i
	typedef logic [NUM_TAGGED:1][U_WIDTH-1:0] u_bits_t;

endpackage

`default_nettype wire

//--- design/update_commit.sv
`default_nettype none

// register stage for the update decisions
// every output is a one-cycle pulse following the update strobe
module update_commit (
	input  logic                       CLK,
	input  logic                       rst_n,
	input  logic                       update_en,
	input  logic                       pred_final,
	input  logic                       outcome,
	output logic                       mispredict,
	input  tage_update_pkg::bank_vec_t ctr_inc_nx,
	input  tage_update_pkg::bank_vec_t ctr_dec_nx,
	input  tage_update_pkg::tag_vec_t  u_inc_nx,
	input  tage_update_pkg::tag_vec_t  u_dec_nx,
	input  logic                       alloc_nx,
	output tage_update_pkg::bank_vec_t ctr_inc,
	output tage_update_pkg::bank_vec_t ctr_dec,
	output tage_update_pkg::tag_vec_t  u_inc,
	output tage_update_pkg::tag_vec_t  u_dec,
	output logic                       alloc
);

	// final direction disagreed with the resolved branch
	assign mispredict = pred_final ^ outcome;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			ctr_inc <= '0;
			ctr_dec <= '0;
			u_inc   <= '0;
			u_dec   <= '0;
			alloc   <= 1'b0;
		end else if (update_en) begin
			ctr_inc <= ctr_inc_nx;
			ctr_dec <= ctr_dec_nx;
			u_inc   <= u_inc_nx;
			u_dec   <= u_dec_nx;
			alloc   <= alloc_nx;
		end else begin
			// idle cycle, drop last pulse
			ctr_inc <= '0;
			ctr_dec <= '0;
			u_inc   <= '0;
			u_dec   <= '0;
			alloc   <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- design/useful_alloc.sv
`default_nettype none

// usefulness increments and decrements, plus the allocation request
// on a mispredict the victim is flagged on the decrement lines
module useful_alloc (
	input  tage_update_pkg::bank_vec_t provider,
	input  tage_update_pkg::tag_vec_t  alt_hit,
	input  tage_update_pkg::bank_vec_t bank_pred,
	input  logic                       pred_final,
	input  logic                       mispredict,
	input  tage_update_pkg::u_bits_t   u_bits,
	output tage_update_pkg::tag_vec_t  u_inc_nx,
	output tage_update_pkg::tag_vec_t  u_dec_nx,
	output logic                       alloc_nx
);

	tage_update_pkg::tag_vec_t prov_tag;	// provider one-hot, tagged banks only
	tage_update_pkg::tag_vec_t agree;	// bank direction equals final prediction
	tage_update_pkg::tag_vec_t above;	// banks with longer history than provider
	tage_update_pkg::tag_vec_t zero_u;	// usefulness field is zero
	tage_update_pkg::tag_vec_t victim;	// lowest zero-usefulness bank above provider

	assign prov_tag = provider[tage_update_pkg::NUM_TAGGED:1];
	assign agree    = ~(bank_pred[tage_update_pkg::NUM_TAGGED:1] ^
			{tage_update_pkg::NUM_TAGGED{pred_final}});

	// scan upward from the provider for an allocation candidate
	always_comb begin
		logic below;	// provider sits at or under the current bank
		logic claimed;

		below   = provider[0];
		claimed = 1'b0;
		above   = '0;
		zero_u  = '0;
		victim  = '0;

		for (int i = 1; i <= tage_update_pkg::NUM_TAGGED; i++) begin
			above[i]  = below;
			below     = below | provider[i];
			zero_u[i] = (u_bits[i] == '0);
			if (above[i] && zero_u[i] && !claimed) begin
				victim[i] = 1'b1;
				claimed   = 1'b1;
			end
		end
	end

	always_comb begin
		u_inc_nx = '0;
		u_dec_nx = '0;
		alloc_nx = 1'b0;

		if (mispredict) begin
			// provider was wrong, it loses usefulness
			if (victim != '0) begin
				alloc_nx = 1'b1;
				u_dec_nx = prov_tag | victim;
			end else begin
				// nothing free above, age every longer table
				u_dec_nx = prov_tag | above;
			end
		end else begin
			u_inc_nx = prov_tag | (alt_hit & agree);
			u_dec_nx = alt_hit & ~agree;	// alternates that disagreed
		end
	end

endmodule

`default_nettype wire

//--- verif/tage_update_chk.sv
`default_nettype none

// output consistency properties, bound into tage_update
module tage_update_chk (
	input logic                       CLK,
	input logic                       rst_n,
	input tage_update_pkg::bank_vec_t ctr_inc,
	input tage_update_pkg::bank_vec_t ctr_dec,
	input tage_update_pkg::tag_vec_t  u_inc,
	input tage_update_pkg::tag_vec_t  u_dec,
	input logic                       alloc
);

	int fail_count = 0;	// failed assertions so far

	// no field moves up and down in the same update
	inc_dec_exclusive: assert property (@(posedge CLK) disable iff (!rst_n)
		((ctr_inc & ctr_dec) == '0) && ((u_inc & u_dec) == '0))
		else begin
			fail_count++;
			$error("increment and decrement of one bank set together");
		end

	// only the provider counter moves
	one_counter: assert property (@(posedge CLK) disable iff (!rst_n)
		$onehot0(ctr_inc | ctr_dec))
		else begin
			fail_count++;
			$error("more than one prediction counter active");
		end

	// allocation only follows a mispredict, which never raises usefulness
	alloc_no_inc: assert property (@(posedge CLK) disable iff (!rst_n)
		alloc |-> (u_inc == '0))
		else begin
			fail_count++;
			$error("alloc together with a usefulness increment");
		end

	alloc_marks_victim: assert property (@(posedge CLK) disable iff (!rst_n)
		alloc |-> (u_dec != '0))
		else begin
			fail_count++;
			$error("alloc without a marked victim");
		end

endmodule

`default_nettype wire

//--- verif/tage_update_mon.sv
`default_nettype none

// compares DUT outputs with the expected values of the previous update
// outputs settle right after the rising edge, so the falling edge is a safe sample point
module tage_update_mon (
	input  logic                       CLK,
	input  tage_update_pkg::bank_vec_t ctr_inc,
	input  tage_update_pkg::bank_vec_t ctr_dec,
	input  tage_update_pkg::tag_vec_t  u_inc,
	input  tage_update_pkg::tag_vec_t  u_dec,
	input  logic                       alloc,
	input  tage_update_pkg::bank_vec_t exp_ctr_inc,
	input  tage_update_pkg::bank_vec_t exp_ctr_dec,
	input  tage_update_pkg::tag_vec_t  exp_u_inc,
	input  tage_update_pkg::tag_vec_t  exp_u_dec,
	input  logic                       exp_alloc,
	output int                         err_count,
	output int                         check_count
);

	int errs   = 0;
	int checks = 0;

	assign err_count   = errs;
	assign check_count = checks;

	task automatic compare_field(
		input string      name,
		input logic [7:0] got,
		input logic [7:0] want
	);
		if (got !== want) begin
			errs++;
			$display("ERROR at time %0t: %s is %0h, expected %0h", $time, name, got, want);
		end
	endtask

	always @(negedge CLK) begin
		checks++;
		compare_field("ctr_inc", {3'b000, ctr_inc}, {3'b000, exp_ctr_inc});
		compare_field("ctr_dec", {3'b000, ctr_dec}, {3'b000, exp_ctr_dec});
		compare_field("u_inc", {4'h0, u_inc}, {4'h0, exp_u_inc});
		compare_field("u_dec", {4'h0, u_dec}, {4'h0, exp_u_dec});
		compare_field("alloc", {7'h00, alloc}, {7'h00, exp_alloc});	// victim request
	end

endmodule

`default_nettype wire

//--- verif/tage_update_tb.sv
`default_nettype none

// testbench for the TAGE update controller
// each data line is one update plus the outputs it should produce one clock later
module tage_update_tb;

	localparam int NUM_VEC     = 40;
	localparam int FIELDS      = 11;	// hex words per data line
	localparam int RESET_CYC   = 10;
	localparam int CYCLE_LIMIT = NUM_VEC + RESET_CYC + 20;
	localparam int DRIVE_DELAY = 5;

	// word offsets inside a data line
	localparam int F_EN      = 0;
	localparam int F_PRED    = 1;
	localparam int F_OUTCOME = 2;
	localparam int F_HIT     = 3;
	localparam int F_BPRED   = 4;
	localparam int F_UBITS   = 5;
	localparam int F_CTR_INC = 6;
	localparam int F_CTR_DEC = 7;
	localparam int F_U_INC   = 8;
	localparam int F_U_DEC   = 9;
	localparam int F_ALLOC   = 10;

	logic                       CLK = 1'b0;
	logic                       rst_n;
	logic                       update_en;
	logic                       pred_final;
	logic                       outcome;
	tage_update_pkg::tag_vec_t  hit;
	tage_update_pkg::bank_vec_t bank_pred;
	tage_update_pkg::u_bits_t   u_bits;

	tage_update_pkg::bank_vec_t ctr_inc;
	tage_update_pkg::bank_vec_t ctr_dec;
	tage_update_pkg::tag_vec_t  u_inc;
	tage_update_pkg::tag_vec_t  u_dec;
	logic                       alloc;

	// expected outputs of the update sampled on the previous edge
	tage_update_pkg::bank_vec_t exp_ctr_inc;
	tage_update_pkg::bank_vec_t exp_ctr_dec;
	tage_update_pkg::tag_vec_t  exp_u_inc;
	tage_update_pkg::tag_vec_t  exp_u_dec;
	logic                       exp_alloc;

	logic [7:0] vec_mem [0:NUM_VEC*FIELDS-1];

	int mon_errors;
	int mon_checks;
	int assert_errors;
	int cycle_count = 0;

	always #50 CLK = ~CLK;

	tage_update dut_i (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.update_en  (update_en),
		.pred_final (pred_final),
		.outcome    (outcome),
		.hit        (hit),
		.bank_pred  (bank_pred),
		.u_bits     (u_bits),
		.ctr_inc    (ctr_inc),
		.ctr_dec    (ctr_dec),
		.u_inc      (u_inc),
		.u_dec      (u_dec),
		.alloc      (alloc)
	);

	tage_update_mon mon_i (
		.CLK         (CLK),
		.ctr_inc     (ctr_inc),
		.ctr_dec     (ctr_dec),
		.u_inc       (u_inc),
		.u_dec       (u_dec),
		.alloc       (alloc),
		.exp_ctr_inc (exp_ctr_inc),
		.exp_ctr_dec (exp_ctr_dec),
		.exp_u_inc   (exp_u_inc),
		.exp_u_dec   (exp_u_dec),
		.exp_alloc   (exp_alloc),
		.err_count   (mon_errors),
		.check_count (mon_checks)
	);

	bind tage_update tage_update_chk chk_i (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.ctr_inc (ctr_inc),
		.ctr_dec (ctr_dec),
		.u_inc   (u_inc),
		.u_dec   (u_dec),
		.alloc   (alloc)
	);

	task automatic apply_vector(input int k);
		int base;

		base       = k * FIELDS;
		update_en  = vec_mem[base + F_EN][0];
		pred_final = vec_mem[base + F_PRED][0];
		outcome    = vec_mem[base + F_OUTCOME][0];
		hit        = vec_mem[base + F_HIT][3:0];
		bank_pred  = vec_mem[base + F_BPRED][4:0];
		u_bits     = vec_mem[base + F_UBITS];
	endtask

	task automatic idle_inputs();
		update_en  = 1'b0;
		pred_final = 1'b0;
		outcome    = 1'b0;
		hit        = '0;
		bank_pred  = '0;
		u_bits     = '0;
	endtask

	task automatic expect_vector(input int k);
		int base;

		base        = k * FIELDS;
		exp_ctr_inc = vec_mem[base + F_CTR_INC][4:0];
		exp_ctr_dec = vec_mem[base + F_CTR_DEC][4:0];
		exp_u_inc   = vec_mem[base + F_U_INC][3:0];
		exp_u_dec   = vec_mem[base + F_U_DEC][3:0];
		exp_alloc   = vec_mem[base + F_ALLOC][0];
	endtask

	task automatic expect_idle();
		exp_ctr_inc = '0;
		exp_ctr_dec = '0;
		exp_u_inc   = '0;
		exp_u_dec   = '0;
		exp_alloc   = 1'b0;
	endtask

	// stop a run that never reaches its verdict
	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout: no verdict after %0d clock cycles", CYCLE_LIMIT);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		rst_n = 1'b0;
		idle_inputs();
		expect_idle();
		$readmemh("verif/tage_update_testdata.txt", vec_mem);

		repeat (RESET_CYC) @(posedge CLK);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		// one update per cycle, results checked one clock later
		for (int k = 0; k < NUM_VEC; k++) begin
			@(posedge CLK);
			#DRIVE_DELAY;
			apply_vector(k);
			if (k > 0) begin
				expect_vector(k - 1);
			end
		end

		@(posedge CLK);
		#DRIVE_DELAY;
		idle_inputs();
		expect_vector(NUM_VEC - 1);
		@(posedge CLK);
		#DRIVE_DELAY;
		expect_idle();
		@(posedge CLK);
		#DRIVE_DELAY;

		assert_errors = dut_i.chk_i.fail_count;
		$display("checks %0d, compare errors %0d, assertion errors %0d",
			mon_checks, mon_errors, assert_errors);
		if (mon_errors == 0 && assert_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/tage_update_testdata.txt
// one update per line, every field in hex
// en pf oc hit bpred ubits  ctr_inc ctr_dec u_inc u_dec alloc
// idle and bimodal provider
0 0 0 0 00 00  00 00 0 0 0
1 1 1 0 01 00  01 00 0 0 0
1 0 0 0 00 00  00 01 0 0 0
0 1 0 f 1f ff  00 00 0 0 0
1 1 1 0 1f 00  01 00 0 0 0
// correct prediction with tagged hits
1 1 1 2 04 00  04 00 2 0 0
1 1 1 7 04 00  00 08 6 1 0
1 0 0 f 16 00  10 00 c 3 0
1 1 1 9 03 ff  00 10 9 0 0
1 0 0 5 08 00  08 00 5 0 0
1 1 1 1 02 00  02 00 1 0 0
// mispredict with a free entry above the provider
1 1 0 0 01 00  00 01 0 1 1
1 0 1 0 00 09  01 00 0 4 1
1 1 0 2 04 34  00 04 0 a 1
1 0 1 3 00 00  04 00 0 6 1
1 1 0 4 08 3f  00 08 0 c 1
1 0 1 1 02 06  00 02 0 5 1
// mispredict with all banks above in use, and provider bank 4
1 1 0 0 00 55  01 00 0 f 0
1 0 1 2 04 b0  00 04 0 e 0
1 1 0 8 10 00  00 10 0 8 0
1 0 1 f 00 00  10 00 0 8 0
1 0 1 4 00 40  08 00 0 c 0
1 1 0 1 03 fc  00 02 0 f 0
0 0 0 0 00 00  00 00 0 0 0
// mixed section
1 0 0 6 1a 7c  08 00 6 0 0
1 1 0 a 0d 21  10 00 0 8 0
1 1 1 0 12 93  00 01 0 0 0
0 1 0 5 0f 00  00 00 0 0 0
1 0 1 1 19 e4  02 00 0 f 0
1 0 1 3 06 8d  00 04 0 6 1
1 1 1 e 15 00  10 00 a 4 0
1 0 0 b 1e 5a  10 00 8 3 0
1 1 0 4 01 3c  08 00 0 c 1
1 0 1 0 1f 5d  00 01 0 f 0
1 1 1 d 0b c6  00 10 d 0 0
1 1 0 2 00 4f  04 00 0 6 1
1 0 0 7 17 12  00 08 4 3 0
1 0 1 9 10 00  00 10 0 8 0
1 1 0 1 1c 70  02 00 0 3 1
0 0 0 0 00 00  00 00 0 0 0

//--- verilog.f
design/tage_update_pkg.sv
design/provider_select.sv
design/counter_update.sv
design/useful_alloc.sv
design/update_commit.sv
design/tage_update.sv
verif/tage_update_chk.sv
verif/tage_update_mon.sv
verif/tage_update_tb.sv
